// ==== common/core_pkg.sv ====
//******************************
// core widths, opcodes, enums and the structs passed between units
//******************************
package core_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    localparam int DMEM_WORDS     = 256;
    localparam int DMEM_IDX_W     = $clog2(DMEM_WORDS);

    localparam int RETIRE_CREDITS = 2;
    localparam int CREDIT_W       = $clog2(RETIRE_CREDITS + 1);

    // rv32i major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // unknown opcode
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        inst_type_e            inst_type;
        alu_op_e               alu_op;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [XLEN-1:0] inst;
    } fetch_resp_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [XLEN-1:0]       rd_wdata;
        logic [XLEN-1:0]       next_pc;
    } retire_t;

endpackage

// ==== decode/inst_decoder.sv ====
//******************************
// instruction field split, format, immediate and alu op
//******************************
`timescale 1ns/1ps

module inst_decoder
    import core_pkg::*;
(
    input  logic [XLEN-1:0] inst,
    output decoded_t        dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    inst_type_e inst_type;
    alu_op_e    alu_op;
    logic [XLEN-1:0] imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            OP_REG:                     inst_type = TYPE_R;
            OP_IMM, OP_LOAD, OP_JALR:   inst_type = TYPE_I;
            OP_STORE:                   inst_type = TYPE_S;
            OP_BRANCH:                  inst_type = TYPE_B;
            OP_LUI, OP_AUIPC:           inst_type = TYPE_U;
            OP_JAL:                     inst_type = TYPE_J;
            default:                    inst_type = TYPE_N;
        endcase
    end

    always_comb begin
        case (inst_type)
            TYPE_I:  imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_S:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            TYPE_B:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            TYPE_U:  imm = {inst[31:12], 12'b0};
            TYPE_J:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // everything outside OP_REG/OP_IMM uses the adder
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OP_REG || opcode == OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (inst_type == TYPE_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm;
        dec.inst_type = inst_type;
        dec.alu_op    = alu_op;
    end

endmodule

// ==== execute/exec_unit.sv ====
//******************************
// alu, branch compare and next pc
//******************************
`timescale 1ns/1ps

module exec_unit
    import core_pkg::*;
(
    input  decoded_t        dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic [XLEN-1:0] alu_result,
    output logic [XLEN-1:0] next_pc
);

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [4:0]      shamt;
    logic            taken;

    always_comb begin
        case (dec.inst_type)
            TYPE_R: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            TYPE_I, TYPE_S: begin
                alu_a = rs1_data;
                alu_b = dec.imm;
            end
            TYPE_U: begin
                alu_a = (dec.opcode == OP_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            TYPE_B, TYPE_J: begin  // target through the adder
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> shamt);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (dec.inst_type == TYPE_J || (dec.inst_type == TYPE_B && taken))
            next_pc = alu_result;
        else if (dec.opcode == OP_JALR)
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        else
            next_pc = pc + 32'd4;
    end

endmodule

// ==== execute/load_store_unit.sv ====
//******************************
// data ram, masked stores, extending loads
//******************************
`timescale 1ns/1ps

module load_store_unit
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  decoded_t        dec,
    input  logic            inst_valid,
    input  logic            retire_fire,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_data,
    output logic            lsu_done,
    output logic [XLEN-1:0] load_data
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    logic                  is_load;
    logic                  is_store;
    logic                  access;
    logic                  done_q;
    logic [DMEM_IDX_W-1:0] idx;
    logic [1:0]            offset;
    logic [3:0]            byte_mask;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       rword;

    assign is_load  = dec.opcode == OP_LOAD;
    assign is_store = dec.opcode == OP_STORE;
    assign access   = inst_valid && (is_load || is_store) && !done_q;  // once per instruction
    assign idx      = addr[DMEM_IDX_W+1:2];
    assign offset   = addr[1:0];

    always_comb begin
        case (dec.funct3[1:0])
            2'b00: begin
                byte_mask = 4'b0001 << offset;
                wdata     = {4{store_data[7:0]}};
            end
            2'b01: begin
                byte_mask = 4'b0011 << offset;
                wdata     = {2{store_data[15:0]}};
            end
            default: begin
                byte_mask = 4'b1111;
                wdata     = store_data;
            end
        endcase
    end

    assign rword = mem[idx] >> {offset, 3'b000};

    always_ff @(posedge clk) begin
        if (access && is_store) begin
            for (int b = 0; b < 4; b++)
                if (byte_mask[b])
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
        if (access && is_load) begin
            case (dec.funct3)
                3'b000:  load_data <= {{24{rword[7]}}, rword[7:0]};
                3'b001:  load_data <= {{16{rword[15]}}, rword[15:0]};
                3'b100:  load_data <= {24'b0, rword[7:0]};
                3'b101:  load_data <= {16'b0, rword[15:0]};
                default: load_data <= rword;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            done_q <= 1'b0;
        else if (retire_fire)
            done_q <= 1'b0;
        else if (access)
            done_q <= 1'b1;
    end

    // non-memory instructions complete with the fetch
    assign lsu_done = (is_load || is_store) ? done_q : inst_valid;

endmodule

// ==== fetch/fetch_unit.sv ====
//******************************
// pc register, fetch request and instruction capture
//******************************
`timescale 1ns/1ps

module fetch_unit
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    output logic            fetch_req_valid,
    output fetch_req_t      fetch_req,
    input  logic            fetch_resp_valid,
    input  fetch_resp_t     fetch_resp,
    input  logic            retire_fire,
    input  logic [XLEN-1:0] next_pc,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] inst,
    output logic            inst_valid
);

    logic req_pending;
    logic issue;  // request goes out on the next clock

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= RESET_PC;
            req_pending <= 1'b0;
            issue       <= 1'b1;
            inst_valid  <= 1'b0;
        end else begin
            if (issue)
                req_pending <= 1'b1;
            else if (fetch_resp_valid)
                req_pending <= 1'b0;

            if (fetch_resp_valid) begin
                inst_valid <= 1'b1;
            end else if (retire_fire) begin
                inst_valid <= 1'b0;
                pc         <= next_pc;  // latched before the retired write lands
            end

            issue <= retire_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_resp_valid)
            inst <= fetch_resp.inst;
    end

    assign fetch_req_valid = req_pending;
    assign fetch_req.addr  = pc;

    // single outstanding request, the environment never answers unasked
    assert property (@(posedge clk) disable iff (reset) fetch_resp_valid |-> req_pending)
        else $error("fetch response without a pending request");

endmodule

// ==== list.f ====
+incdir+test
common/core_pkg.sv
fetch/fetch_unit.sv
decode/inst_decoder.sv
source/reg_file.sv
execute/exec_unit.sv
execute/load_store_unit.sv
source/retire_unit.sv
source/core_top.sv
test/core_tb.sv

// ==== source/core_top.sv ====
//******************************
// rv32i multi-cycle core top
//******************************
`timescale 1ns/1ps

module core_top
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic        fetch_req_valid,
    output fetch_req_t  fetch_req,
    input  logic        fetch_resp_valid,
    input  fetch_resp_t fetch_resp,
    output logic        retire_valid,
    output retire_t     retire,
    input  logic        credit_return
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic            inst_valid;
    decoded_t        dec;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] next_pc;
    logic            lsu_done;
    logic [XLEN-1:0] load_data;
    logic            retire_fire;
    logic            rf_we;
    logic [XLEN-1:0] rf_wdata;

    fetch_unit u_fetch (
        .clk              (clk),
        .reset            (reset),
        .fetch_req_valid  (fetch_req_valid),
        .fetch_req        (fetch_req),
        .fetch_resp_valid (fetch_resp_valid),
        .fetch_resp       (fetch_resp),
        .retire_fire      (retire_fire),
        .next_pc          (next_pc),
        .pc               (pc),
        .inst             (inst),
        .inst_valid       (inst_valid)
    );

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata)
    );

    exec_unit u_exec (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    load_store_unit u_lsu (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .inst_valid  (inst_valid),
        .retire_fire (retire_fire),
        .addr        (alu_result),
        .store_data  (rs2_data),
        .lsu_done    (lsu_done),
        .load_data   (load_data)
    );

    retire_unit u_retire (
        .clk           (clk),
        .reset         (reset),
        .dec           (dec),
        .pc            (pc),
        .inst          (inst),
        .alu_result    (alu_result),
        .load_data     (load_data),
        .next_pc       (next_pc),
        .lsu_done      (lsu_done),
        .credit_return (credit_return),
        .retire_fire   (retire_fire),
        .rf_we         (rf_we),
        .rf_wdata      (rf_wdata),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

// ==== source/reg_file.sv ====
//******************************
// 32 x 32 register file, 2R1W
//******************************
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];  // x0 hardwired
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== source/retire_unit.sv ====
//******************************
// writeback select, retire credits, retire record
//******************************
`timescale 1ns/1ps

module retire_unit
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  decoded_t        dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] load_data,
    input  logic [XLEN-1:0] next_pc,
    input  logic            lsu_done,
    input  logic            credit_return,
    output logic            retire_fire,
    output logic            rf_we,
    output logic [XLEN-1:0] rf_wdata,
    output logic            retire_valid,
    output retire_t         retire
);

    logic [CREDIT_W-1:0] credits;
    logic                wb_en;

    always_comb begin
        if (dec.opcode == OP_LOAD)
            rf_wdata = load_data;
        else if (dec.opcode == OP_JAL || dec.opcode == OP_JALR)
            rf_wdata = pc + 32'd4;  // link
        else
            rf_wdata = alu_result;
    end

    assign wb_en = (dec.inst_type inside {TYPE_R, TYPE_I, TYPE_U, TYPE_J}) && (dec.rd != '0);

    assign retire_fire = lsu_done && (credits != '0);
    assign rf_we       = retire_fire && wb_en;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits      <= CREDIT_W'(RETIRE_CREDITS);
            retire_valid <= 1'b0;
        end else begin
            case ({retire_fire, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            retire_valid <= retire_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_fire) begin
            retire.pc       <= pc;
            retire.inst     <= inst;
            retire.rd       <= dec.rd;
            retire.rd_we    <= wb_en;
            retire.rd_wdata <= wb_en ? rf_wdata : '0;
            retire.next_pc  <= next_pc;
        end
    end

    // environment must not hand back credits it never took
    assert property (@(posedge clk) disable iff (reset) credits <= RETIRE_CREDITS)
        else $error("retire credit count above %0d", RETIRE_CREDITS);

endmodule

// ==== test/core_model.svh ====
//******************************
// instruction encoders and reference model of one rv32i step
//******************************
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// alt picks sub / sra
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic retire_t model_step(input logic [31:0] pc, input logic [31:0] inst);
    retire_t     r;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] val;
    logic        we;
    logic        take;
    op    = inst[6:0];
    f3    = inst[14:12];
    rd    = inst[11:7];
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    val   = '0;
    we    = 1'b0;
    r     = '0;
    r.pc      = pc;
    r.inst    = inst;
    r.rd      = rd;
    r.next_pc = pc + 32'd4;
    case (op)
        OP_REG: begin
            val = alu_ref(f3, inst[30], a, b);
            we  = 1'b1;
        end
        OP_IMM: begin
            val = alu_ref(f3, f3 == 3'd5 && inst[30], a, imm_i);
            we  = 1'b1;
        end
        OP_LUI: begin
            val = {inst[31:12], 12'b0};
            we  = 1'b1;
        end
        OP_AUIPC: begin
            val = pc + {inst[31:12], 12'b0};
            we  = 1'b1;
        end
        OP_JAL: begin
            val       = pc + 32'd4;
            we        = 1'b1;
            r.next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OP_JALR: begin
            val       = pc + 32'd4;
            we        = 1'b1;
            r.next_pc = (a + imm_i) & ~32'd1;
        end
        OP_BRANCH: begin
            case (f3)
                3'd0:    take = a == b;
                3'd1:    take = a != b;
                3'd4:    take = $signed(a) < $signed(b);
                3'd5:    take = $signed(a) >= $signed(b);
                3'd6:    take = a < b;
                3'd7:    take = a >= b;
                default: take = 1'b0;
            endcase
            if (take)
                r.next_pc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        OP_LOAD: begin
            addr = a + imm_i;
            word = model_mem[addr[DMEM_IDX_W+1:2]] >> (8 * addr[1:0]);
            case (f3)
                3'd0:    val = {{24{word[7]}}, word[7:0]};
                3'd1:    val = {{16{word[15]}}, word[15:0]};
                3'd4:    val = {24'b0, word[7:0]};
                3'd5:    val = {16'b0, word[15:0]};
                default: val = word;
            endcase
            we = 1'b1;
        end
        OP_STORE: begin
            addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            word = model_mem[addr[DMEM_IDX_W+1:2]];
            for (int j = 0; j < (1 << f3[1:0]) && j < 4; j++)
                word[8 * (addr[1:0] + j) +: 8] = b[8 * j +: 8];
            model_mem[addr[DMEM_IDX_W+1:2]] = word;
        end
        default: ;  // unknown opcode retires as a no-op
    endcase
    if (we && rd != 5'd0) begin
        model_regs[rd] = val;
        r.rd_we        = 1'b1;
        r.rd_wdata     = val;
    end
    return r;
endfunction

`endif

// ==== test/core_tb.sv ====
//******************************
// core testbench: program responder, credit driver, retire checks
//******************************
`timescale 1ns/1ps

module core_tb
    import core_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        fetch_req_valid;
    fetch_req_t  fetch_req;
    logic        fetch_resp_valid;
    fetch_resp_t fetch_resp;
    logic        retire_valid;
    retire_t     retire;
    logic        credit_return;

    integer      seed = 32'h383f;
    logic [31:0] prog [$];
    int          sect_start [4];  // first program index of each test
    logic [31:0] end_pc;
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [DMEM_WORDS];
    logic [31:0] model_pc = RESET_PC;
    logic [31:0] last_next_pc = RESET_PC;
    int          resp_count = 0;
    int          other_errors = 0;
    int          retired [4];
    int          errs [4];

    `include "core_model.svh"

    core_top core_i (
        .clk              (clk),
        .reset            (reset),
        .fetch_req_valid  (fetch_req_valid),
        .fetch_req        (fetch_req),
        .fetch_resp_valid (fetch_resp_valid),
        .fetch_resp       (fetch_resp),
        .retire_valid     (retire_valid),
        .retire           (retire),
        .credit_return    (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rand_alu();
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = $random(seed);
        s  = $random(seed);
        f3 = r[2:0];
        f7 = (r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        case (r[5:4])
            2'b00: return enc_r(f7, s[4:0], s[9:5], f3, s[14:10]);
            2'b01: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    return enc_i({f7, s[4:0]}, s[9:5], f3, s[14:10], OP_IMM);  // shifts
                return enc_i(s[31:20], s[9:5], f3, s[14:10], OP_IMM);
            end
            2'b10:   return enc_u(s[31:12], r[10:6], OP_LUI);
            default: return enc_u(s[31:12], r[10:6], OP_AUIPC);
        endcase
    endfunction

    // naturally aligned access inside the first 64 bytes
    function automatic logic [31:0] rand_mem();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] a;
        r  = $random(seed);
        f3 = r[3:1];
        if (f3 == 3'd3 || f3 == 3'd7)
            f3 = 3'd2;
        else if (f3 == 3'd6)
            f3 = 3'd4;
        a = {6'b0, r[13:8]};
        if (f3[1:0] == 2'd1)
            a[0] = 1'b0;
        else if (f3[1:0] == 2'd2)
            a[1:0] = 2'b00;
        if (r[0])
            return enc_s(a, r[18:14], 5'd0, {1'b0, f3[1:0]});
        return enc_i(a, 5'd0, f3, r[23:19], OP_LOAD);
    endfunction

    task automatic emit_flow();
        logic [31:0] r;
        logic [2:0]  f3;
        r  = $random(seed);
        f3 = r[4:2];
        if (f3 == 3'd2 || f3 == 3'd3)
            f3 = f3 + 3'd4;
        case (r[1:0])
            2'b00, 2'b01: prog.push_back(enc_b(13'd8, r[6] ? r[11:7] : r[16:12], r[11:7], f3));
            2'b10:        prog.push_back(enc_j(21'd8, r[11:7]));
            default: begin
                prog.push_back(enc_u(20'd0, 5'd5, OP_AUIPC));
                prog.push_back(enc_i(12'd13, 5'd5, 3'd0, r[11:7], OP_JALR));  // odd target
            end
        endcase
        prog.push_back(rand_alu());  // skipped when taken
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (idx < prog.size())
            return prog[idx];
        return 32'h0000_0013;  // nop past the end
    endfunction

    function automatic int section_of(input logic [31:0] addr);
        logic [31:0] idx;
        int          t;
        idx = (addr - RESET_PC) >> 2;
        t   = 0;
        for (int k = 1; k < 4; k++)
            if (idx >= sect_start[k])
                t = k;
        return t;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "alu";
            1:       return "mem";
            2:       return "branch";
            default: return "mixed";
        endcase
    endfunction

    task automatic check_field(input int t, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s: %s expected %h actual %h", test_name(t), field, exp, act);
            errs[t]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %s done: %0d retired, %0d errors", test_name(t), retired[t], errs[t]);
    endtask

    initial begin : main
        logic [31:0] r;
        logic [11:0] a;
        reset = 1'b1;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int k = 0; k < 4; k++) begin
            retired[k] = 0;
            errs[k]    = 0;
        end
        sect_start[0] = 0;
        repeat (16) begin
            r = $random(seed);
            prog.push_back(enc_u(r[31:12], r[4:0], OP_LUI));
        end
        prog.push_back(enc_i(12'h123, 5'd1, 3'd0, 5'd0, OP_IMM));  // write to x0
        repeat (60) prog.push_back(rand_alu());
        sect_start[1] = prog.size();
        a = '0;
        repeat (16) begin
            r = $random(seed);
            prog.push_back(enc_s(a, r[4:0], 5'd0, 3'd2));  // fill window with sw
            a = a + 12'd4;
        end
        repeat (40) prog.push_back(rand_mem());
        sect_start[2] = prog.size();
        prog.push_back(enc_j(21'd12, 5'd1));
        prog.push_back(enc_j(21'd12, 5'd0));
        prog.push_back(rand_alu());               // never reached
        prog.push_back(enc_j(21'h1f_fff8, 5'd2));  // back by 8
        repeat (24) emit_flow();
        sect_start[3] = prog.size();
        repeat (100) begin
            r = $random(seed);
            case (r[2:0])
                3'd0, 3'd1, 3'd2: prog.push_back(rand_alu());
                3'd3, 3'd4:       prog.push_back(rand_mem());
                3'd5, 3'd6:       emit_flow();
                default:          prog.push_back({r[31:7], 7'b0001011});  // unknown opcode
            endcase
        end
        end_pc = RESET_PC + 4 * prog.size();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // watchdog
        repeat (prog.size() * 20) @(posedge clk);
        $display("timeout: program did not finish within %0d cycles", prog.size() * 20);
        $display("Simulation FAILED");
        $finish;
    end

    // instruction memory with 0 to 3 extra cycles of latency
    initial begin : responder
        int delay;
        fetch_resp_valid = 1'b0;
        fetch_resp       = '0;
        forever begin
            @(negedge clk);
            if (fetch_req_valid === 1'b1) begin
                if (fetch_req.addr !== last_next_pc) begin
                    $display("Error fetch: address expected %h actual %h",
                             last_next_pc, fetch_req.addr);
                    other_errors++;
                end
                delay = $random(seed) & 3;
                repeat (delay) @(negedge clk);
                fetch_resp.inst  = fetch_word(fetch_req.addr);
                fetch_resp_valid = 1'b1;
                resp_count++;
                @(negedge clk);
                fetch_resp_valid = 1'b0;
            end
        end
    end

    initial begin : credit_driver
        int taken;
        int returned;
        int hold;
        taken         = 0;
        returned      = 0;
        hold          = 0;
        credit_return = 1'b0;
        forever begin
            @(negedge clk);
            credit_return = 1'b0;
            if (retire_valid === 1'b1)
                taken++;
            if (taken > RETIRE_CREDITS + returned) begin
                $display("core retired %0d records with only %0d credits returned",
                         taken, returned);
                other_errors++;
            end
            if (hold > 0)
                hold--;
            else if (($random(seed) & 63) == 0)
                hold = 10 + ($random(seed) & 15);  // withhold for a stretch
            else if (taken > returned && ($random(seed) & 1)) begin
                credit_return = 1'b1;
                returned++;
            end
        end
    end

    initial begin : compare
        retire_t exp;
        int      t;
        int      cur;
        int      total_ret;
        int      total_err;
        logic    done;
        cur  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (retire_valid !== 1'b0) begin
                if (resp_count == 0) begin
                    $display("retire record seen before any fetch response");
                    other_errors++;
                end
                t = section_of(model_pc);
                while (cur < t) begin
                    report_test(cur);
                    cur++;
                end
                exp = model_step(model_pc, fetch_word(model_pc));
                check_field(t, "pc", exp.pc, retire.pc);
                check_field(t, "inst", exp.inst, retire.inst);
                check_field(t, "rd", exp.rd, retire.rd);
                check_field(t, "rd_we", exp.rd_we, retire.rd_we);
                check_field(t, "rd_wdata", exp.rd_wdata, retire.rd_wdata);
                check_field(t, "next_pc", exp.next_pc, retire.next_pc);
                retired[t]++;
                model_pc     = exp.next_pc;
                last_next_pc = exp.next_pc;
                done         = model_pc >= end_pc;
            end
        end
        while (cur < 4) begin
            report_test(cur);
            cur++;
        end
        total_ret = 0;
        total_err = other_errors;
        for (int k = 0; k < 4; k++) begin
            total_ret += retired[k];
            total_err += errs[k];
        end
        $display("tests 4, retired %0d, other errors %0d, total errors %0d",
                 total_ret, other_errors, total_err);
        if (total_err == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
